//--- logic/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder import ahb_pkg::*; #(
    parameter int ITCM_AW = 14
) (
    input  logic      clk,
    input  logic      rst_n,
    input  ahb_req_t  req,
    input  logic      hready,
    input  logic      itcm_hreadyout,
    input  logic      itcm_hresp,
    input  ahb_data_t itcm_hrdata,
    input  logic      def_hreadyout,
    input  logic      def_hresp,
    input  ahb_data_t def_hrdata,
    output logic      hsel_itcm,
    output logic      hsel_def,
    output ahb_data_t hrdata_out,
    output logic      hready_out,
    output logic      hresp_out
);

    localparam int REGION_LSB = ITCM_AW + 2;  // Byte offset bits inside the ITCM

    logic itcm_hit;
    logic dp_itcm;    // ITCM owns the data phase

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address phase select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign itcm_hit  = (req.haddr[31:REGION_LSB] == ITCM_BASE[31:REGION_LSB]);
    assign hsel_itcm = itcm_hit;
    assign hsel_def  = !itcm_hit;  // Everything else is unmapped

    // Owner follows the address phase once the bus moves on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_itcm <= 1'b1;
        end else if (hready) begin
            dp_itcm <= hsel_itcm;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data phase response mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (dp_itcm) begin
            hrdata_out = itcm_hrdata;
            hready_out = itcm_hreadyout;
            hresp_out  = itcm_hresp;
        end else begin
            hrdata_out = def_hrdata;
            hready_out = def_hreadyout;
            hresp_out  = def_hresp;
        end
    end

endmodule : ahb_decoder

//--- logic/ahb_default_slave.sv
`timescale 1ns/1ps

module ahb_default_slave import ahb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hsel,
    input  ahb_req_t  req,
    input  logic      hready,
    output logic      hreadyout,
    output logic      hresp,
    output ahb_data_t hrdata
);

    typedef enum logic [1:0] {
        IDLE,
        ERR1,   // ERROR with hready low
        ERR2    // ERROR with hready high
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   accept;

    assign accept = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = ERR1;
                end
            end
            ERR1:    state_nxt = ERR2;
            ERR2:    state_nxt = accept ? ERR1 : IDLE;  // Back to back errors
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign hreadyout = (state != ERR1);
    assign hresp     = (state == IDLE) ? HRESP_OKAY : HRESP_ERROR;
    assign hrdata    = '0;

    a_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
        !hreadyout |=> hreadyout);

endmodule : ahb_default_slave

//--- logic/ahb_pkg.sv
package ahb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] ahb_addr_t;
    typedef logic [31:0] ahb_data_t;
    typedef logic [3:0]  byte_en_t;   // One enable per byte lane

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transfer encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } ahb_trans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } ahb_size_e;

    // Address phase of one transfer
    typedef struct packed {
        ahb_addr_t  haddr;
        ahb_trans_e htrans;
        ahb_size_e  hsize;
        logic       hwrite;
    } ahb_req_t;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // ITCM sits at the bottom of the map
    localparam ahb_addr_t ITCM_BASE = 32'h0000_0000;

endpackage : ahb_pkg

//--- logic/ahb_to_sram.sv
`timescale 1ns/1ps

module ahb_to_sram import ahb_pkg::*; #(
    parameter int ITCM_AW = 14
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hsel,
    input  ahb_req_t           req,
    input  logic               hready,
    input  ahb_data_t          hwdata,
    input  ahb_data_t          sram_rdata,
    output logic               hreadyout,
    output logic               hresp,
    output ahb_data_t          hrdata,
    output logic [ITCM_AW-1:0] sram_addr,
    output ahb_data_t          sram_wdata,
    output byte_en_t           sram_be,
    output logic               sram_cs
);

    typedef logic [ITCM_AW-1:0] word_addr_t;

    logic       accept;
    logic       rd_req;
    logic       wr_req;
    word_addr_t req_waddr;
    byte_en_t   req_be;

    logic       dp_write;     // Write data phase in progress
    word_addr_t dp_waddr;
    byte_en_t   dp_be;

    logic       buf_valid;
    word_addr_t buf_waddr;
    ahb_data_t  buf_data;
    byte_en_t   buf_be;

    ahb_data_t  fwd_data;
    byte_en_t   fwd_be;
    ahb_data_t  fwd_data_q;
    byte_en_t   fwd_be_q;

    function automatic byte_en_t lane_mask(ahb_size_e size, logic [1:0] offs);
        byte_en_t mask;
        case (size)
            BYTE:    mask = byte_en_t'(4'b0001 << offs);
            HALF:    mask = offs[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic ahb_data_t merge_lanes(ahb_data_t base, ahb_data_t upd, byte_en_t be);
        ahb_data_t res;
        res = base;
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            if (be[i]) begin
                res[8*i +: 8] = upd[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign accept    = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);
    assign rd_req    = accept && !req.hwrite;
    assign wr_req    = accept && req.hwrite;
    assign req_waddr = req.haddr[ITCM_AW+1:2];
    assign req_be    = lane_mask(req.hsize, req.haddr[1:0]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM port, reads first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sram_cs    = 1'b0;
        sram_addr  = req_waddr;
        sram_wdata = buf_data;
        sram_be    = '0;
        if (rd_req) begin
            sram_cs = 1'b1;
        end else if (buf_valid) begin
            sram_cs   = 1'b1;   // Drain the pending write
            sram_addr = buf_waddr;
            sram_be   = buf_be;
        end else if (dp_write) begin
            sram_cs    = 1'b1;  // Port free, write straight from the bus
            sram_addr  = dp_waddr;
            sram_wdata = hwdata;
            sram_be    = dp_be;
        end
    end

    // Newest copy of the word a read is asking for
    always_comb begin
        fwd_data = buf_valid ? buf_data : hwdata;
        fwd_be   = '0;
        if (buf_valid && buf_waddr == req_waddr) begin
            fwd_be = buf_be;
        end else if (dp_write && dp_waddr == req_waddr) begin
            fwd_be = dp_be;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_write  <= 1'b0;
            buf_valid <= 1'b0;
            fwd_be_q  <= '0;
        end else begin
            dp_write  <= wr_req;
            buf_valid <= rd_req && (buf_valid || dp_write);  // Held while reads own the port
            if (rd_req) begin
                fwd_be_q <= fwd_be;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) begin
            dp_waddr <= req_waddr;
            dp_be    <= req_be;
        end
        if (dp_write) begin
            buf_waddr <= dp_waddr;
            buf_data  <= hwdata;
            buf_be    <= dp_be;
        end
        if (rd_req) begin
            fwd_data_q <= fwd_data;
        end
    end

    assign hrdata    = merge_lanes(sram_rdata, fwd_data_q, fwd_be_q);
    assign hreadyout = 1'b1;        // Zero wait states
    assign hresp     = HRESP_OKAY;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ((req.hsize == BYTE) ||
                    (req.hsize == HALF && !req.haddr[0]) ||
                    (req.hsize == WORD && req.haddr[1:0] == 2'b00)));

    a_no_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (hsel && hready) |-> (req.htrans != BUSY));

endmodule : ahb_to_sram

//--- logic/itcm.sv
`timescale 1ns/1ps

module itcm import ahb_pkg::*; #(
    parameter int ITCM_AW = 14
) (
    input  logic               clk,
    input  logic [ITCM_AW-1:0] addr,
    input  ahb_data_t          wdata,
    input  byte_en_t           be,
    input  logic               cs,
    output ahb_data_t          rdata
);

    localparam int DEPTH = 2 ** ITCM_AW;
    localparam int LANES = $bits(byte_en_t);

    ahb_data_t mem [DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single port, byte lane writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (cs) begin
            for (int i = 0; i < LANES; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Read word registered, holds until the next read
    always_ff @(posedge clk) begin
        if (cs && be == '0) begin
            rdata <= mem[addr];
        end
    end

endmodule : itcm

//--- logic/soc_mem.sv
`timescale 1ns/1ps

module soc_mem import ahb_pkg::*; #(
    parameter int ITCM_AW = 14
) (
    input  logic      clk,
    input  logic      rst_n,
    input  ahb_req_t  req,
    input  ahb_data_t hwdata,
    output ahb_data_t hrdata,
    output logic      hready,
    output logic      hresp
);

    logic               hsel_itcm;
    logic               hsel_def;

    logic               itcm_hreadyout;
    logic               itcm_hresp;
    ahb_data_t          itcm_hrdata;
    logic               def_hreadyout;
    logic               def_hresp;
    ahb_data_t          def_hrdata;

    // ITCM port
    logic [ITCM_AW-1:0] sram_addr;
    ahb_data_t          sram_wdata;
    ahb_data_t          sram_rdata;
    byte_en_t           sram_be;
    logic               sram_cs;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode and response mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ahb_decoder #(.ITCM_AW(ITCM_AW)) u_ahb_decoder (
        .clk           (clk           ),
        .rst_n         (rst_n         ),
        .req           (req           ),
        .hready        (hready        ),  // Fed back from the mux
        .itcm_hreadyout(itcm_hreadyout),
        .itcm_hresp    (itcm_hresp    ),
        .itcm_hrdata   (itcm_hrdata   ),
        .def_hreadyout (def_hreadyout ),
        .def_hresp     (def_hresp     ),
        .def_hrdata    (def_hrdata    ),
        .hsel_itcm     (hsel_itcm     ),
        .hsel_def      (hsel_def      ),
        .hrdata_out    (hrdata        ),
        .hready_out    (hready        ),
        .hresp_out     (hresp         )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slaves
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ahb_to_sram #(.ITCM_AW(ITCM_AW)) u_ahb_itcm (
        .clk       (clk           ),
        .rst_n     (rst_n         ),
        .hsel      (hsel_itcm     ),
        .req       (req           ),
        .hready    (hready        ),
        .hwdata    (hwdata        ),
        .sram_rdata(sram_rdata    ),
        .hreadyout (itcm_hreadyout),
        .hresp     (itcm_hresp    ),
        .hrdata    (itcm_hrdata   ),
        .sram_addr (sram_addr     ),
        .sram_wdata(sram_wdata    ),
        .sram_be   (sram_be       ),
        .sram_cs   (sram_cs       )
    );

    itcm #(.ITCM_AW(ITCM_AW)) u_itcm (
        .clk  (clk       ),
        .addr (sram_addr ),
        .wdata(sram_wdata),
        .be   (sram_be   ),
        .cs   (sram_cs   ),
        .rdata(sram_rdata)
    );

    ahb_default_slave u_default_slave (
        .clk      (clk          ),
        .rst_n    (rst_n        ),
        .hsel     (hsel_def     ),
        .req      (req          ),
        .hready   (hready       ),
        .hreadyout(def_hreadyout),
        .hresp    (def_hresp    ),
        .hrdata   (def_hrdata   )
    );

endmodule : soc_mem

//--- soc_mem.f
logic/ahb_pkg.sv
logic/ahb_decoder.sv
logic/ahb_to_sram.sv
logic/itcm.sv
logic/ahb_default_slave.sv
logic/soc_mem.sv
verification/tb_soc_mem.sv

//--- verification/soc_mem_golden.txt
# name op(R/W/I) addr(hex) size(0 byte,1 half,2 word) wdata(hex) rdata(hex) resp(0 ok,1 err)
# last column: 1 allows 0-2 random idle cycles after the transfer
idle_reset   I 00000000 2 00000000 00000000 0 0
wr_word0     W 00000000 2 11223344 00000000 0 1
wr_word1     W 00000004 2 a5a5f00d 00000000 0 0
rd_word0     R 00000000 2 00000000 11223344 0 1
rd_word1     R 00000004 2 00000000 a5a5f00d 0 1
wr_top       W 0000fffc 2 deadbeef 00000000 0 1
rd_top       R 0000fffc 2 00000000 deadbeef 0 1
wr_base      W 00000020 2 01234567 00000000 0 0
wr_byte1     W 00000021 0 0000ab00 00000000 0 0
wr_half_hi   W 00000022 1 cdef0000 00000000 0 1
wr_byte0     W 00000020 0 00000099 00000000 0 1
rd_merged    R 00000020 2 00000000 cdefab99 0 1
wr_half_lo   W 00000020 1 00005a5a 00000000 0 0
rd_half_fwd  R 00000020 2 00000000 cdef5a5a 0 1
wr_fwd       W 00000040 2 cafef00d 00000000 0 0
rd_fwd       R 00000040 2 00000000 cafef00d 0 1
wr_old       W 00000048 2 76543210 00000000 0 1
wr_new       W 00000044 2 0badc0de 00000000 0 0
rd_other     R 00000048 2 00000000 76543210 0 0
rd_buffered  R 00000044 2 00000000 0badc0de 0 0
wr_byte2     W 00000046 0 00ee0000 00000000 0 0
rd_byte_fwd  R 00000044 2 00000000 0beec0de 0 1
idle_mid     I 00000000 2 00000000 00000000 0 0
wr_unmapped  W 00010040 2 ffffffff 00000000 1 0
rd_unmapped  R 00020000 2 00000000 00000000 1 0
idle_err     I 00000000 2 00000000 00000000 0 0
rd_after_err R 00000040 2 00000000 cafef00d 0 1
rd_top_again R 0000fffc 2 00000000 deadbeef 0 0
idle_end     I 00000000 2 00000000 00000000 0 0

//--- verification/tb_soc_mem.sv
`timescale 1ns/1ps

module tb_soc_mem import ahb_pkg::*; ();

    localparam int ITCM_AW   = 14;
    localparam int MAX_TESTS = 64;
    localparam int SEED      = 69668;
    localparam GOLDEN_FILE   = "verification/soc_mem_golden.txt";

    logic      clk;
    logic      rst_n;
    ahb_req_t  req;
    ahb_data_t hwdata;
    ahb_data_t hrdata;
    logic      hready;
    logic      hresp;

    // Transfer list from the golden file
    string     t_name  [MAX_TESTS];
    string     t_op    [MAX_TESTS];
    ahb_addr_t t_addr  [MAX_TESTS];
    int        t_size  [MAX_TESTS];
    ahb_data_t t_wdata [MAX_TESTS];
    ahb_data_t t_rdata [MAX_TESTS];
    logic      t_resp  [MAX_TESTS];
    int        t_gap   [MAX_TESTS];
    int        n_tests;
    logic      loaded;

    int        pass_cnt;
    int        fail_cnt;
    int        bus_errors;   // Failures outside any test
    bit        cur_bad;      // Test in its data phase has failed

    soc_mem #(.ITCM_AW(ITCM_AW)) i_soc_mem (
        .clk   (clk   ),
        .rst_n (rst_n ),
        .req   (req   ),
        .hwdata(hwdata),
        .hrdata(hrdata),
        .hready(hready),
        .hresp (hresp )
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Golden file and master helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_golden();
        int        fd;
        int        c;
        int        cnt;
        string     name;
        string     op;
        ahb_addr_t addr;
        int        size;
        ahb_data_t wd;
        ahb_data_t rd;
        int        resp;
        int        gap;
        n_tests = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            bus_errors++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name.substr(0, 0) == "#") begin
                    c = $fgetc(fd);  // Skip rest of a comment line
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    cnt = $fscanf(fd, "%s %h %d %h %h %d %d", op, addr, size, wd, rd, resp, gap);
                    if (cnt == 7 && n_tests < MAX_TESTS) begin
                        t_name[n_tests]  = name;
                        t_op[n_tests]    = op;
                        t_addr[n_tests]  = addr;
                        t_size[n_tests]  = size;
                        t_wdata[n_tests] = wd;
                        t_rdata[n_tests] = rd;
                        t_resp[n_tests]  = (resp != 0);
                        t_gap[n_tests]   = gap;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("The golden file holds no transfers");
                bus_errors++;
            end
        end
        loaded = 1'b1;
    endtask

    task automatic drive_addr(int idx);
        req.haddr  = t_addr[idx];
        req.hsize  = ahb_size_e'(t_size[idx]);
        req.hwrite = (t_op[idx] == "W");
        req.htrans = (t_op[idx] == "I") ? IDLE : NONSEQ;
    endtask

    task automatic drive_idle();
        req.htrans = IDLE;
        req.hwrite = 1'b0;
    endtask

    // An ERROR response costs exactly one wait cycle, OKAY none
    task automatic check_completion(int idx, int waits, logic rsp, ahb_data_t rd);
        int exp_waits;
        exp_waits = (t_resp[idx] == HRESP_ERROR) ? 1 : 0;
        assert (waits == exp_waits) else begin
            $display("ERROR %s: wait cycles expected %0d actual %0d",
                     t_name[idx], exp_waits, waits);
            cur_bad = 1'b1;
        end
        assert (rsp === t_resp[idx]) else begin
            $display("ERROR %s: hresp expected %b actual %b", t_name[idx], t_resp[idx], rsp);
            cur_bad = 1'b1;
        end
        if (t_op[idx] == "R") begin
            assert (rd === t_rdata[idx]) else begin
                $display("ERROR %s: hrdata expected %h actual %h",
                         t_name[idx], t_rdata[idx], rd);
                cur_bad = 1'b1;
            end
        end
        if (cur_bad) begin
            fail_cnt++;
            $display("FAIL %s", t_name[idx]);
        end else begin
            pass_cnt++;
            $display("PASS %s", t_name[idx]);
        end
        cur_bad = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Master model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int          bus_idx;   // Transfer in its address phase, -1 if none
        int          issued;
        int          gap_left;
        int          cur;
        int          waits;
        logic        rdy;
        logic        rsp;
        ahb_data_t   rd;
        int          q_pend [$];

        void'($urandom(SEED));
        rst_n      = 1'b0;
        req        = '0;
        hwdata     = '0;
        loaded     = 1'b0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        bus_errors = 0;
        cur_bad    = 1'b0;
        load_golden();
        repeat (16) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        bus_idx  = -1;
        issued   = 0;
        gap_left = 0;
        waits    = 0;

        while (issued < n_tests || bus_idx >= 0 || q_pend.size() > 0) begin
            @(negedge clk);   // Responses settled mid cycle
            rdy = hready;
            rsp = hresp;
            rd  = hrdata;
            if (q_pend.size() == 0) begin
                assert (rdy === 1'b1 && rsp === HRESP_OKAY) else begin
                    $display("ERROR idle bus: hready/hresp expected 1/0 actual %b/%b", rdy, rsp);
                    bus_errors++;
                end
            end else begin
                cur = q_pend[0];
                if (rdy !== 1'b1) begin
                    waits++;
                    assert (rsp === HRESP_ERROR) else begin
                        $display("ERROR %s: hresp in wait cycle expected 1 actual %b",
                                 t_name[cur], rsp);
                        cur_bad = 1'b1;
                    end
                end else begin
                    check_completion(cur, waits, rsp, rd);
                    void'(q_pend.pop_front());
                    waits = 0;
                end
            end

            @(posedge clk);
            #1;
            if (rdy === 1'b1) begin
                // Address phase on the bus was accepted at this edge
                if (bus_idx >= 0) begin
                    q_pend.push_back(bus_idx);
                    hwdata = (t_op[bus_idx] == "W") ? t_wdata[bus_idx] : '0;
                end else begin
                    hwdata = '0;
                end
                if (gap_left > 0) begin
                    drive_idle();
                    gap_left--;
                    bus_idx = -1;
                end else if (issued < n_tests) begin
                    drive_addr(issued);
                    bus_idx = issued;
                    if (t_gap[issued] != 0) begin
                        gap_left = $urandom_range(2, 0);
                    end
                    issued++;
                end else begin
                    drive_idle();
                    bus_idx = -1;
                end
            end
        end

        $display("Tests: %0d passed, %0d failed, %0d bus errors",
                 pass_cnt, fail_cnt, bus_errors);
        if (fail_cnt == 0 && bus_errors == 0 && n_tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Worst case is four cycles per transfer including gaps and error waits
    initial begin
        int limit;
        wait (loaded === 1'b1);
        limit = n_tests * 4 + 100;
        wait (rst_n === 1'b1);
        repeat (limit) @(posedge clk);
        $display("Timeout: the transfer list did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule : tb_soc_mem
